//--- src/rw_mgr_cfg_pkg.sv
/*
 * Read/write manager configuration
 * Default geometry of the memory interface and width of the host bus.
 * The top level takes these as parameter defaults and passes them down.
 */
package rw_mgr_cfg_pkg;

	// each afi cycle carries 2*AFI_RATIO data words
	localparam int AFI_RATIO = 2;
	localparam int DQ_PER_DQS = 8;
	localparam int DQS_GROUPS = 2;

	localparam int AC_BUS_WIDTH = 8;
	localparam int CS_WIDTH = 2;

	localparam int AVL_DATA_WIDTH = 32;
	localparam int AVL_ADDR_WIDTH = 12;

endpackage

//--- src/rw_mgr_isa_pkg.sv
/*
 * Read/write manager instruction set
 * Instruction word layout, host command opcodes, sequencer states
 * and the data/mask pattern rule shared by the write and read paths.
 */
package rw_mgr_isa_pkg;

	localparam int INST_WIDTH = 18;
	localparam int PC_WIDTH = 7;
	localparam int AC_ADDR_WIDTH = 6;
	localparam int CNTR_WIDTH = 8;

	typedef logic [3:0] do_code_t;
	typedef logic [2:0] dm_code_t;

	// top bit first
	typedef struct packed {
		logic return_code;
		logic read;
		logic jump;
		logic [1:0] jump_reg;
		logic [AC_ADDR_WIDTH-1:0] ac_addr;
		do_code_t do_code;
		dm_code_t dm_code;
	} inst_t;

	typedef enum logic [3:0] {
		CMD_RUN_SINGLE = 4'd0,
		CMD_RUN_ALL    = 4'd1,
		CMD_LOAD_CNTR  = 4'd2,
		CMD_LOAD_JUMP  = 4'd3,
		CMD_CLEAR_ERR  = 4'd4,
		CMD_SET_MASK   = 4'd5,
		CMD_WRITE_INST = 4'd6,
		CMD_WRITE_AC   = 4'd7
	} cmd_opcode_e;

	typedef enum logic [1:0] {
		IDLE,
		RUNNING,
		READING,
		DONE
	} seq_state_e;

	// word w of a group is all ones when bit (w mod 4) of the data code is set
	function automatic logic do_word(input do_code_t code, input int unsigned w);
		return code[w % 4];
	endfunction

	function automatic logic dm_bit(input dm_code_t code, input int unsigned w);
		return code[w % 3];
	endfunction

endpackage

//--- src/rw_mgr_cmd_decoder.sv
/*
 * Host command decoder
 * Registers the host bus into the afi domain and turns the opcode in
 * address bits 11:8 into a typed command with a one-cycle valid strobe.
 * Also serves the readback word: error word at 0, PC at 1.
 */
`timescale 1ns/1ps
module rw_mgr_cmd_decoder (
	input  logic afi_clk,
	input  logic afi_reset_n,
	input  logic cmd_write_i,
	input  logic cmd_read_i,
	input  logic [rw_mgr_cfg_pkg::AVL_ADDR_WIDTH-1:0] avl_address_i,
	input  logic [rw_mgr_cfg_pkg::AVL_DATA_WIDTH-1:0] avl_writedata_i,
	input  logic [rw_mgr_cfg_pkg::DQ_PER_DQS-1:0] error_word_i,
	input  logic [rw_mgr_isa_pkg::PC_WIDTH-1:0] pc_i,
	output rw_mgr_isa_pkg::cmd_opcode_e cmd_e_o,
	output logic cmd_valid_o,
	output logic cmd_active_o,
	output logic [rw_mgr_cfg_pkg::AVL_ADDR_WIDTH-1:0] addr_q_o,
	output logic [rw_mgr_cfg_pkg::AVL_DATA_WIDTH-1:0] data_q_o,
	output logic [rw_mgr_cfg_pkg::AVL_DATA_WIDTH-1:0] avl_readdata_o
);
	import rw_mgr_cfg_pkg::*;
	import rw_mgr_isa_pkg::*;

	logic cmd_write_q;
	logic cmd_write_d;
	logic cmd_read_q;

	always_ff @(posedge afi_clk or negedge afi_reset_n) begin
		if (!afi_reset_n) begin
			cmd_write_q <= 1'b0;
			cmd_write_d <= 1'b0;
			cmd_read_q <= 1'b0;
		end else begin
			cmd_write_q <= cmd_write_i;
			cmd_write_d <= cmd_write_q;
			cmd_read_q <= cmd_read_i;
		end
	end

	always_ff @(posedge afi_clk) begin
		addr_q_o <= avl_address_i;
		data_q_o <= avl_writedata_i;
	end

	// the host holds its strobe until done, so only the rising edge is a command
	assign cmd_valid_o = cmd_write_q && !cmd_write_d;
	assign cmd_active_o = cmd_write_q || cmd_read_q;
	assign cmd_e_o = cmd_opcode_e'(addr_q_o[11:8]);

	always_comb begin
		avl_readdata_o = '0;
		if (addr_q_o == AVL_ADDR_WIDTH'(0))
			avl_readdata_o[DQ_PER_DQS-1:0] = error_word_i;
		else if (addr_q_o == AVL_ADDR_WIDTH'(1))
			avl_readdata_o[PC_WIDTH-1:0] = pc_i;
	end

endmodule

//--- src/rw_mgr_sequencer.sv
/*
 * Program sequencer
 * Command state machine, program counter and the writable instruction
 * memory. The memory is read at the next PC, so fields of the selected
 * instruction appear one cycle later.
 */
`timescale 1ns/1ps
module rw_mgr_sequencer #(
	parameter int PC_WIDTH = rw_mgr_isa_pkg::PC_WIDTH
) (
	input  logic afi_clk,
	input  logic afi_reset_n,
	input  rw_mgr_isa_pkg::cmd_opcode_e cmd_e_i,
	input  logic cmd_valid_i,
	input  logic cmd_active_i,
	input  logic cmd_read_i,
	input  logic [rw_mgr_cfg_pkg::AVL_ADDR_WIDTH-1:0] addr_q_i,
	input  logic [rw_mgr_cfg_pkg::AVL_DATA_WIDTH-1:0] data_q_i,
	input  logic jump_taken_i,
	input  logic [PC_WIDTH-1:0] jump_addr_i,
	output rw_mgr_isa_pkg::inst_t inst_o,
	output logic [PC_WIDTH-1:0] pc_o,
	output logic group_mode_o,
	output logic loopback_o,
	output logic cmd_done_o
);
	import rw_mgr_isa_pkg::*;

	seq_state_e state;
	inst_t inst_mem [2**PC_WIDTH];
	inst_t inst_q;
	logic [PC_WIDTH-1:0] next_pc;
	logic run_cmd;

	assign run_cmd = cmd_valid_i && (cmd_e_i == CMD_RUN_SINGLE || cmd_e_i == CMD_RUN_ALL);

	// outside a run the datapath sees an all-zero instruction
	assign inst_o = (state == RUNNING) ? inst_q : '0;
	assign cmd_done_o = (state == DONE);

	always_comb begin
		next_pc = pc_o;
		if (state == IDLE && run_cmd) begin
			next_pc = data_q_i[PC_WIDTH-1:0];
		end else if (state == RUNNING) begin
			if (jump_taken_i)
				next_pc = jump_addr_i;
			else if (!inst_o.return_code)
				next_pc = pc_o + 1'b1;
		end
	end

	always_ff @(posedge afi_clk) begin
		if (cmd_valid_i && cmd_e_i == CMD_WRITE_INST)
			inst_mem[addr_q_i[PC_WIDTH-1:0]] <= inst_t'(data_q_i[INST_WIDTH-1:0]);
		inst_q <= inst_mem[next_pc];
	end

	always_ff @(posedge afi_clk or negedge afi_reset_n) begin
		if (!afi_reset_n) begin
			state <= IDLE;
			pc_o <= '0;
			group_mode_o <= 1'b0;
			loopback_o <= 1'b0;
		end else begin
			pc_o <= next_pc;
			case (state)
				IDLE: begin
					if (run_cmd) begin
						state <= RUNNING;
						group_mode_o <= (cmd_e_i == CMD_RUN_ALL);
						loopback_o <= addr_q_i[7];
					end else if (cmd_read_i) begin
						state <= READING;
					end else if (cmd_valid_i) begin
						state <= DONE;
					end
				end
				RUNNING: begin
					if (inst_o.return_code)
						state <= DONE;
				end
				READING: begin
					state <= DONE;
				end
				DONE: begin
					if (!cmd_active_i)
						state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

//--- src/rw_mgr_jump_logic.sv
/*
 * Loop counters and jump targets
 * Four down counters, each with a reload value, and four jump targets.
 * A jump through a nonzero counter decrements it and branches; at zero
 * the counter reloads and execution falls through.
 */
`timescale 1ns/1ps
module rw_mgr_jump_logic (
	input  logic afi_clk,
	input  logic afi_reset_n,
	input  logic cntr_load_i,
	input  logic jump_load_i,
	input  logic [1:0] reg_sel_i,
	input  logic [rw_mgr_isa_pkg::CNTR_WIDTH-1:0] value_i,
	input  logic jump_i,
	input  logic [1:0] jump_reg_i,
	output logic jump_taken_o,
	output logic [rw_mgr_isa_pkg::PC_WIDTH-1:0] jump_addr_o,
	output logic [rw_mgr_isa_pkg::CNTR_WIDTH-1:0] cntr3_o
);
	import rw_mgr_isa_pkg::*;

	logic [CNTR_WIDTH-1:0] cntr [4];
	logic [CNTR_WIDTH-1:0] reload [4];
	logic [PC_WIDTH-1:0] target [4];

	assign jump_taken_o = jump_i && (cntr[jump_reg_i] != '0);
	assign jump_addr_o = target[jump_reg_i];
	assign cntr3_o = cntr[3];

	always_ff @(posedge afi_clk or negedge afi_reset_n) begin
		if (!afi_reset_n) begin
			for (int i = 0; i < 4; i++) begin
				cntr[i] <= '0;
				reload[i] <= '0;
				target[i] <= '0;
			end
		end else begin
			if (cntr_load_i) begin
				cntr[reg_sel_i] <= value_i;
				reload[reg_sel_i] <= value_i;
			end
			if (jump_load_i)
				target[reg_sel_i] <= value_i[PC_WIDTH-1:0];
			if (jump_i) begin
				if (cntr[jump_reg_i] != '0)
					cntr[jump_reg_i] <= cntr[jump_reg_i] - 1'b1;
				else
					cntr[jump_reg_i] <= reload[jump_reg_i];
			end
		end
	end

endmodule

//--- src/rw_mgr_ac_table.sv
/*
 * Address/command table
 * Writable table of AC words read synchronously by the instruction's
 * ac_addr field. Chip selects are ORed with the host mask and ODT
 * picks one of two host masks.
 */
`timescale 1ns/1ps
module rw_mgr_ac_table #(
	parameter int AC_BUS_WIDTH = rw_mgr_cfg_pkg::AC_BUS_WIDTH,
	parameter int CS_WIDTH = rw_mgr_cfg_pkg::CS_WIDTH
) (
	input  logic afi_clk,
	input  logic afi_reset_n,
	input  logic wr_en_i,
	input  logic [rw_mgr_isa_pkg::AC_ADDR_WIDTH-1:0] wr_addr_i,
	input  logic [rw_mgr_cfg_pkg::AVL_DATA_WIDTH-1:0] wr_data_i,
	input  logic mask_en_i,
	input  logic [rw_mgr_cfg_pkg::AVL_DATA_WIDTH-1:0] mask_data_i,
	input  logic [rw_mgr_isa_pkg::AC_ADDR_WIDTH-1:0] ac_addr_i,
	output logic [AC_BUS_WIDTH-1:0] ac_bus_o,
	output logic [CS_WIDTH-1:0] ac_masked_bus_o,
	output logic [CS_WIDTH-1:0] afi_odt_o
);
	import rw_mgr_isa_pkg::*;

	// a table word is the AC bus, then the chip-select bit, then the ODT select bit
	localparam int WORD_WIDTH = AC_BUS_WIDTH + 2;

	logic [WORD_WIDTH-1:0] ac_mem [2**AC_ADDR_WIDTH];
	logic [WORD_WIDTH-1:0] word_q;
	logic [CS_WIDTH-1:0] cs_mask;
	logic [CS_WIDTH-1:0] odt0_mask;
	logic [CS_WIDTH-1:0] odt1_mask;

	always_ff @(posedge afi_clk) begin
		if (wr_en_i)
			ac_mem[wr_addr_i] <= wr_data_i[WORD_WIDTH-1:0];
		word_q <= ac_mem[ac_addr_i];
	end

	always_ff @(posedge afi_clk or negedge afi_reset_n) begin
		if (!afi_reset_n) begin
			cs_mask <= '0;
			odt0_mask <= '0;
			odt1_mask <= '0;
		end else if (mask_en_i) begin
			cs_mask <= mask_data_i[CS_WIDTH-1:0];
			odt0_mask <= mask_data_i[8 +: CS_WIDTH];
			odt1_mask <= mask_data_i[16 +: CS_WIDTH];
		end
	end

	assign ac_bus_o = word_q[AC_BUS_WIDTH-1:0];
	// chip selects are active low, a set mask bit keeps that rank deselected
	assign ac_masked_bus_o = {CS_WIDTH{word_q[AC_BUS_WIDTH]}} | cs_mask;
	assign afi_odt_o = word_q[AC_BUS_WIDTH+1] ? odt1_mask : odt0_mask;

endmodule

//--- src/rw_mgr_write_path.sv
/*
 * Write data path
 * Expands the instruction's data and mask codes into one group's words,
 * registers them and broadcasts them to every DQS group.
 */
`timescale 1ns/1ps
module rw_mgr_write_path #(
	parameter int AFI_RATIO = rw_mgr_cfg_pkg::AFI_RATIO,
	parameter int DQ_PER_DQS = rw_mgr_cfg_pkg::DQ_PER_DQS,
	parameter int DQS_GROUPS = rw_mgr_cfg_pkg::DQS_GROUPS
) (
	input  logic afi_clk,
	input  logic afi_reset_n,
	input  rw_mgr_isa_pkg::do_code_t do_code_i,
	input  rw_mgr_isa_pkg::dm_code_t dm_code_i,
	output logic [DQ_PER_DQS*DQS_GROUPS*2*AFI_RATIO-1:0] afi_wdata_o,
	output logic [DQS_GROUPS*2*AFI_RATIO-1:0] afi_dm_o,
	output logic [DQ_PER_DQS*2*AFI_RATIO-1:0] group_data_o
);
	import rw_mgr_isa_pkg::*;

	localparam int NUM_WORDS = 2 * AFI_RATIO;

	logic [DQ_PER_DQS*NUM_WORDS-1:0] group_d;
	logic [NUM_WORDS-1:0] dm_d;
	logic [NUM_WORDS-1:0] dm_q;

	always_comb begin
		for (int w = 0; w < NUM_WORDS; w++) begin
			group_d[w*DQ_PER_DQS +: DQ_PER_DQS] = {DQ_PER_DQS{do_word(do_code_i, w)}};
			dm_d[w] = dm_bit(dm_code_i, w);
		end
	end

	always_ff @(posedge afi_clk or negedge afi_reset_n) begin
		if (!afi_reset_n) begin
			group_data_o <= '0;
			dm_q <= '0;
		end else begin
			group_data_o <= group_d;
			dm_q <= dm_d;
		end
	end

	// bus is word-major, each word holds all groups side by side
	always_comb begin
		for (int w = 0; w < NUM_WORDS; w++) begin
			for (int g = 0; g < DQS_GROUPS; g++) begin
				afi_wdata_o[(w*DQS_GROUPS + g)*DQ_PER_DQS +: DQ_PER_DQS] =
					group_data_o[w*DQ_PER_DQS +: DQ_PER_DQS];
				afi_dm_o[w*DQS_GROUPS + g] = dm_q[w];
			end
		end
	end

endmodule

//--- src/rw_mgr_read_checker.sv
/*
 * Read data checker
 * Picks one DQS group from the read bus (or the looped-back write data),
 * matches each valid beat against the oldest queued expected pattern
 * and accumulates every mismatching DQ bit into a sticky error word.
 */
`timescale 1ns/1ps
module rw_mgr_read_checker #(
	parameter int AFI_RATIO = rw_mgr_cfg_pkg::AFI_RATIO,
	parameter int DQ_PER_DQS = rw_mgr_cfg_pkg::DQ_PER_DQS,
	parameter int DQS_GROUPS = rw_mgr_cfg_pkg::DQS_GROUPS
) (
	input  logic afi_clk,
	input  logic afi_reset_n,
	input  logic [DQ_PER_DQS*DQS_GROUPS*2*AFI_RATIO-1:0] afi_rdata_i,
	input  logic afi_rdata_valid_i,
	input  logic [DQ_PER_DQS*2*AFI_RATIO-1:0] loop_data_i,
	input  logic loopback_i,
	input  logic group_mode_i,
	input  logic [rw_mgr_isa_pkg::CNTR_WIDTH-1:0] group_i,
	input  logic [rw_mgr_isa_pkg::CNTR_WIDTH-1:0] cntr3_i,
	input  logic push_i,
	input  rw_mgr_isa_pkg::do_code_t do_code_i,
	input  rw_mgr_isa_pkg::dm_code_t dm_code_i,
	input  logic clear_i,
	output logic [DQ_PER_DQS-1:0] error_word_o
);
	import rw_mgr_isa_pkg::*;

	localparam int NUM_WORDS = 2 * AFI_RATIO;
	localparam int GROUP_BITS = DQ_PER_DQS * NUM_WORDS;

	typedef struct packed {
		do_code_t do_code;
		dm_code_t dm_code;
	} exp_t;

	exp_t exp_fifo [4];
	logic [1:0] wr_ptr;
	logic [1:0] rd_ptr;
	logic [2:0] count;
	logic [CNTR_WIDTH-1:0] group_sel;
	logic [GROUP_BITS-1:0] sel_data;
	logic [GROUP_BITS-1:0] rdata_q;
	logic rvalid_q;
	logic push_q;
	logic [GROUP_BITS-1:0] beat_data;
	logic beat_valid;
	logic [DQ_PER_DQS-1:0] beat_err;
	logic push_ok;
	logic pop;

	assign group_sel = group_mode_i ? cntr3_i : group_i;

	always_comb begin
		sel_data = '0;
		for (int w = 0; w < NUM_WORDS; w++) begin
			for (int g = 0; g < DQS_GROUPS; g++) begin
				if (group_sel == g)
					sel_data[w*DQ_PER_DQS +: DQ_PER_DQS] =
						afi_rdata_i[(w*DQS_GROUPS + g)*DQ_PER_DQS +: DQ_PER_DQS];
			end
		end
	end

	always_ff @(posedge afi_clk) begin
		rdata_q <= sel_data;
	end

	// in loopback the registered write data lines up with the delayed read flag
	assign beat_data = loopback_i ? loop_data_i : rdata_q;
	assign beat_valid = loopback_i ? push_q : rvalid_q;
	assign pop = beat_valid && (count != '0);
	assign push_ok = push_i && (count != 3'd4);

	// masked words are compared like any other word
	always_comb begin
		beat_err = '0;
		for (int w = 0; w < NUM_WORDS; w++)
			beat_err |= beat_data[w*DQ_PER_DQS +: DQ_PER_DQS] ^
				{DQ_PER_DQS{do_word(exp_fifo[rd_ptr].do_code, w)}};
	end

	always_ff @(posedge afi_clk) begin
		if (push_ok)
			exp_fifo[wr_ptr] <= '{do_code: do_code_i, dm_code: dm_code_i};
	end

	always_ff @(posedge afi_clk or negedge afi_reset_n) begin
		if (!afi_reset_n) begin
			rvalid_q <= 1'b0;
			push_q <= 1'b0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			error_word_o <= '0;
		end else begin
			rvalid_q <= afi_rdata_valid_i;
			push_q <= push_i;
			if (push_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + push_ok - pop;
			if (clear_i)
				error_word_o <= '0;
			else if (pop)
				error_word_o <= error_word_o | beat_err;
		end
	end

endmodule

//--- src/rw_mgr_core.sv
/*
 * Read/write manager core
 * Top level of the calibration read/write manager in the afi clock
 * domain. Connects the command decoder, sequencer, jump logic,
 * AC table, write path and read checker.
 */
`timescale 1ns/1ps
module rw_mgr_core #(
	parameter int AFI_RATIO = rw_mgr_cfg_pkg::AFI_RATIO,
	parameter int DQ_PER_DQS = rw_mgr_cfg_pkg::DQ_PER_DQS,
	parameter int DQS_GROUPS = rw_mgr_cfg_pkg::DQS_GROUPS,
	parameter int AC_BUS_WIDTH = rw_mgr_cfg_pkg::AC_BUS_WIDTH,
	parameter int CS_WIDTH = rw_mgr_cfg_pkg::CS_WIDTH,
	parameter int PC_WIDTH = rw_mgr_isa_pkg::PC_WIDTH
) (
	input  logic afi_clk,
	input  logic afi_reset_n,
	input  logic cmd_read_i,
	input  logic cmd_write_i,
	input  logic [rw_mgr_cfg_pkg::AVL_ADDR_WIDTH-1:0] avl_address_i,
	input  logic [rw_mgr_cfg_pkg::AVL_DATA_WIDTH-1:0] avl_writedata_i,
	input  logic [DQ_PER_DQS*DQS_GROUPS*2*AFI_RATIO-1:0] afi_rdata_i,
	input  logic afi_rdata_valid_i,
	output logic [rw_mgr_cfg_pkg::AVL_DATA_WIDTH-1:0] avl_readdata_o,
	output logic cmd_done_o,
	output logic [AC_BUS_WIDTH-1:0] ac_bus_o,
	output logic [CS_WIDTH-1:0] ac_masked_bus_o,
	output logic [CS_WIDTH-1:0] afi_odt_o,
	output logic [DQ_PER_DQS*DQS_GROUPS*2*AFI_RATIO-1:0] afi_wdata_o,
	output logic [DQS_GROUPS*2*AFI_RATIO-1:0] afi_dm_o
);
	import rw_mgr_cfg_pkg::*;
	import rw_mgr_isa_pkg::*;

	cmd_opcode_e cmd_e;
	logic cmd_valid;
	logic cmd_active;
	logic [AVL_ADDR_WIDTH-1:0] addr_q;
	logic [AVL_DATA_WIDTH-1:0] data_q;
	inst_t inst;
	logic [PC_WIDTH-1:0] pc;
	logic [PC_WIDTH-1:0] jump_addr;
	logic jump_taken;
	logic group_mode;
	logic loopback;
	logic [CNTR_WIDTH-1:0] cntr3;
	logic [DQ_PER_DQS*2*AFI_RATIO-1:0] group_data;
	logic [DQ_PER_DQS-1:0] error_word;
	logic cntr_load;
	logic jump_load;
	logic ac_write;
	logic mask_load;
	logic clear_err;

	assign cntr_load = cmd_valid && (cmd_e == CMD_LOAD_CNTR);
	assign jump_load = cmd_valid && (cmd_e == CMD_LOAD_JUMP);
	assign ac_write = cmd_valid && (cmd_e == CMD_WRITE_AC);
	assign mask_load = cmd_valid && (cmd_e == CMD_SET_MASK);
	assign clear_err = cmd_valid && (cmd_e == CMD_CLEAR_ERR);

	rw_mgr_cmd_decoder u_cmd_decoder (
		.afi_clk(afi_clk),
		.afi_reset_n(afi_reset_n),
		.cmd_write_i(cmd_write_i),
		.cmd_read_i(cmd_read_i),
		.avl_address_i(avl_address_i),
		.avl_writedata_i(avl_writedata_i),
		.error_word_i(error_word),
		.pc_i(pc),
		.cmd_e_o(cmd_e),
		.cmd_valid_o(cmd_valid),
		.cmd_active_o(cmd_active),
		.addr_q_o(addr_q),
		.data_q_o(data_q),
		.avl_readdata_o(avl_readdata_o)
	);

	rw_mgr_sequencer #(
		.PC_WIDTH(PC_WIDTH)
	) u_sequencer (
		.afi_clk(afi_clk),
		.afi_reset_n(afi_reset_n),
		.cmd_e_i(cmd_e),
		.cmd_valid_i(cmd_valid),
		.cmd_active_i(cmd_active),
		.cmd_read_i(cmd_read_i),
		.addr_q_i(addr_q),
		.data_q_i(data_q),
		.jump_taken_i(jump_taken),
		.jump_addr_i(jump_addr),
		.inst_o(inst),
		.pc_o(pc),
		.group_mode_o(group_mode),
		.loopback_o(loopback),
		.cmd_done_o(cmd_done_o)
	);

	rw_mgr_jump_logic u_jump_logic (
		.afi_clk(afi_clk),
		.afi_reset_n(afi_reset_n),
		.cntr_load_i(cntr_load),
		.jump_load_i(jump_load),
		.reg_sel_i(addr_q[1:0]),
		.value_i(data_q[CNTR_WIDTH-1:0]),
		.jump_i(inst.jump),
		.jump_reg_i(inst.jump_reg),
		.jump_taken_o(jump_taken),
		.jump_addr_o(jump_addr),
		.cntr3_o(cntr3)
	);

	rw_mgr_ac_table #(
		.AC_BUS_WIDTH(AC_BUS_WIDTH),
		.CS_WIDTH(CS_WIDTH)
	) u_ac_table (
		.afi_clk(afi_clk),
		.afi_reset_n(afi_reset_n),
		.wr_en_i(ac_write),
		.wr_addr_i(addr_q[AC_ADDR_WIDTH-1:0]),
		.wr_data_i(data_q),
		.mask_en_i(mask_load),
		.mask_data_i(data_q),
		.ac_addr_i(inst.ac_addr),
		.ac_bus_o(ac_bus_o),
		.ac_masked_bus_o(ac_masked_bus_o),
		.afi_odt_o(afi_odt_o)
	);

	rw_mgr_write_path #(
		.AFI_RATIO(AFI_RATIO),
		.DQ_PER_DQS(DQ_PER_DQS),
		.DQS_GROUPS(DQS_GROUPS)
	) u_write_path (
		.afi_clk(afi_clk),
		.afi_reset_n(afi_reset_n),
		.do_code_i(inst.do_code),
		.dm_code_i(inst.dm_code),
		.afi_wdata_o(afi_wdata_o),
		.afi_dm_o(afi_dm_o),
		.group_data_o(group_data)
	);

	rw_mgr_read_checker #(
		.AFI_RATIO(AFI_RATIO),
		.DQ_PER_DQS(DQ_PER_DQS),
		.DQS_GROUPS(DQS_GROUPS)
	) u_read_checker (
		.afi_clk(afi_clk),
		.afi_reset_n(afi_reset_n),
		.afi_rdata_i(afi_rdata_i),
		.afi_rdata_valid_i(afi_rdata_valid_i),
		.loop_data_i(group_data),
		.loopback_i(loopback),
		.group_mode_i(group_mode),
		.group_i(addr_q[CNTR_WIDTH-1:0]),
		.cntr3_i(cntr3),
		.push_i(inst.read),
		.do_code_i(inst.do_code),
		.dm_code_i(inst.dm_code),
		.clear_i(clear_err),
		.error_word_o(error_word)
	);

endmodule

//--- tests/tb_rw_mgr_core.sv
/*
 * Testbench for the read/write manager core
 * Loads AC words, masks, loop registers and short programs over the host
 * bus, runs them and checks the AC bus, write data, PC and error word
 * against a reference model of program execution.
 */
`timescale 1ns/1ps
module tb_rw_mgr_core;
	import rw_mgr_cfg_pkg::*;
	import rw_mgr_isa_pkg::*;

	localparam int NUM_WORDS = 2 * AFI_RATIO;
	localparam int WDATA_W = DQ_PER_DQS * DQS_GROUPS * NUM_WORDS;
	localparam int DM_W = DQS_GROUPS * NUM_WORDS;
	// the full sequence takes a few hundred cycles and this limit leaves a wide margin
	localparam int MAX_CYCLES = 4000;
	localparam logic [31:0] RAND_SEED = 32'hb77c_2df3;

	typedef logic [DM_W+WDATA_W-1:0] wbeat_t;
	typedef logic [2*CS_WIDTH+AC_BUS_WIDTH-1:0] acbeat_t;
	typedef logic [AC_BUS_WIDTH+1:0] ac_word_t;
	typedef logic [AVL_DATA_WIDTH-1:0] avl_word_t;
	typedef logic [PC_WIDTH-1:0] pc_t;

	logic afi_clk;
	logic afi_reset_n;
	logic cmd_read;
	logic cmd_write;
	logic [AVL_ADDR_WIDTH-1:0] avl_address;
	avl_word_t avl_writedata;
	logic [WDATA_W-1:0] afi_rdata;
	logic afi_rdata_valid;
	avl_word_t avl_readdata;
	logic cmd_done;
	logic [AC_BUS_WIDTH-1:0] ac_bus;
	logic [CS_WIDTH-1:0] ac_masked_bus;
	logic [CS_WIDTH-1:0] afi_odt;
	logic [WDATA_W-1:0] afi_wdata;
	logic [DM_W-1:0] afi_dm;

	// model of the programmed state
	inst_t prog [2**PC_WIDTH];
	ac_word_t ac_tab [2**AC_ADDR_WIDTH];
	logic [CNTR_WIDTH-1:0] mdl_cntr [4];
	logic [CNTR_WIDTH-1:0] mdl_reload [4];
	pc_t mdl_target [4];
	logic [CS_WIDTH-1:0] cs_mask;
	logic [CS_WIDTH-1:0] odt0_mask;
	logic [CS_WIDTH-1:0] odt1_mask;
	acbeat_t exp_ac [$];
	wbeat_t exp_wr [$];
	pc_t pc_trace [$];

	int errors = 0;
	int checks = 0;
	int cycle_cnt = 0;
	logic run_active;
	int mon_count;
	int mon_beats;
	logic mon_stop;

	rw_mgr_core u_rw_mgr_core (
		.afi_clk(afi_clk),
		.afi_reset_n(afi_reset_n),
		.cmd_read_i(cmd_read),
		.cmd_write_i(cmd_write),
		.avl_address_i(avl_address),
		.avl_writedata_i(avl_writedata),
		.afi_rdata_i(afi_rdata),
		.afi_rdata_valid_i(afi_rdata_valid),
		.avl_readdata_o(avl_readdata),
		.cmd_done_o(cmd_done),
		.ac_bus_o(ac_bus),
		.ac_masked_bus_o(ac_masked_bus),
		.afi_odt_o(afi_odt),
		.afi_wdata_o(afi_wdata),
		.afi_dm_o(afi_dm)
	);

	initial afi_clk = 1'b0;
	always #2 afi_clk = ~afi_clk;

	always @(posedge afi_clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Testbench failed");
			$finish;
		end
	end

	task automatic check_data(input string what, input wbeat_t got, input wbeat_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_ac(input string what, input acbeat_t got, input acbeat_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_word(input string what, input avl_word_t got, input avl_word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_pc(input string what, input pc_t got, input pc_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	// word w of each group is all ones when do bit (w mod 4) is set and masked by dm bit (w mod 3)
	function automatic wbeat_t pattern_beat(input do_code_t do_c, input dm_code_t dm_c);
		wbeat_t beat;
		beat = '0;
		for (int w = 0; w < NUM_WORDS; w++) begin
			for (int g = 0; g < DQS_GROUPS; g++) begin
				beat[(w*DQS_GROUPS + g)*DQ_PER_DQS +: DQ_PER_DQS] = {DQ_PER_DQS{do_c[w % 4]}};
				beat[WDATA_W + w*DQS_GROUPS + g] = dm_c[w % 3];
			end
		end
		return beat;
	endfunction

	// walks the program one instruction per step and queues the expected beats
	function automatic pc_t model_run(input pc_t start);
		pc_t pc;
		inst_t inst;
		ac_word_t word;
		logic taken;
		logic fin;
		int steps;
		pc = start;
		fin = 1'b0;
		steps = 0;
		while (!fin && steps < 256) begin
			inst = prog[pc];
			word = ac_tab[inst.ac_addr];
			pc_trace.push_back(pc);
			exp_ac.push_back({word[AC_BUS_WIDTH+1] ? odt1_mask : odt0_mask,
				{CS_WIDTH{word[AC_BUS_WIDTH]}} | cs_mask, word[AC_BUS_WIDTH-1:0]});
			exp_wr.push_back(pattern_beat(inst.do_code, inst.dm_code));
			taken = 1'b0;
			if (inst.jump) begin
				if (mdl_cntr[inst.jump_reg] != '0) begin
					mdl_cntr[inst.jump_reg] = mdl_cntr[inst.jump_reg] - 1'b1;
					taken = 1'b1;
				end else begin
					mdl_cntr[inst.jump_reg] = mdl_reload[inst.jump_reg];
				end
			end
			if (inst.return_code)
				fin = 1'b1;
			if (taken)
				pc = mdl_target[inst.jump_reg];
			else if (!fin)
				pc = pc + 1'b1;
			steps++;
		end
		return pc;
	endfunction

	function automatic inst_t make_inst(input logic ret, input logic rd, input logic jmp,
			input logic [1:0] jreg, input logic [AC_ADDR_WIDTH-1:0] ac);
		inst_t inst;
		inst.return_code = ret;
		inst.read = rd;
		inst.jump = jmp;
		inst.jump_reg = jreg;
		inst.ac_addr = ac;
		inst.do_code = do_code_t'($urandom);
		inst.dm_code = dm_code_t'($urandom);
		return inst;
	endfunction

	// one beat per instruction and the first appears three edges after the strobe
	always @(negedge afi_clk) begin
		if (!run_active) begin
			mon_count = 0;
			mon_beats = 0;
			mon_stop = 1'b0;
		end else if (!mon_stop) begin
			if (mon_count >= 3) begin
				if (exp_ac.size() == 0) begin
					errors++;
					$display("run produced more instruction beats than the model at %0t", $time);
				end else begin
					check_ac("ac beat", {afi_odt, ac_masked_bus, ac_bus}, exp_ac.pop_front());
					check_data("write beat", {afi_dm, afi_wdata}, exp_wr.pop_front());
				end
				mon_beats++;
				if (cmd_done)
					mon_stop = 1'b1;
			end
			mon_count++;
		end
	end

	task automatic wait_done(input logic level);
		do begin
			@(posedge afi_clk);
			#1;
		end while (cmd_done !== level);
	endtask

	task automatic host_cmd(input cmd_opcode_e op, input logic [7:0] addr_lo, input avl_word_t data);
		@(posedge afi_clk);
		#1;
		avl_address = {op, addr_lo};
		avl_writedata = data;
		cmd_write = 1'b1;
		wait_done(1'b1);
		// done stays up for as long as the strobe is held
		repeat (2) begin
			@(posedge afi_clk);
			#1;
			if (cmd_done !== 1'b1) begin
				errors++;
				$display("FAIL %0t: cmd_done fell while the strobe was still held", $time);
			end
		end
		cmd_write = 1'b0;
		wait_done(1'b0);
	endtask

	task automatic host_read(input logic [7:0] addr_lo, output avl_word_t data);
		@(posedge afi_clk);
		#1;
		avl_address = {4'h0, addr_lo};
		cmd_read = 1'b1;
		wait_done(1'b1);
		data = avl_readdata;
		cmd_read = 1'b0;
		wait_done(1'b0);
	endtask

	task automatic load_inst(input pc_t addr, input inst_t inst);
		prog[addr] = inst;
		host_cmd(CMD_WRITE_INST, 8'(addr), avl_word_t'(inst));
	endtask

	task automatic run_program(input logic [7:0] addr_lo, input pc_t start,
			output pc_t final_pc, output int beats);
		exp_ac.delete();
		exp_wr.delete();
		pc_trace.delete();
		final_pc = model_run(start);
		@(posedge afi_clk);
		#1;
		avl_address = {CMD_RUN_SINGLE, addr_lo};
		avl_writedata = avl_word_t'(start);
		cmd_write = 1'b1;
		run_active = 1'b1;
		wait_done(1'b1);
		cmd_write = 1'b0;
		wait_done(1'b0);
		beats = mon_beats;
		run_active = 1'b0;
		if (beats != pc_trace.size()) begin
			errors++;
			$display("FAIL %0t: run from %0d gave %0d beats but the model executed %0d",
				$time, start, beats, pc_trace.size());
		end
	endtask

	initial begin
		avl_word_t rd;
		avl_word_t mask_word;
		pc_t final_pc;
		int beats;
		int loop_n;
		int flip_w;
		int flip_b;
		inst_t rd_inst;
		wbeat_t beat;
		void'($urandom(RAND_SEED));
		afi_reset_n = 1'b0;
		cmd_read = 1'b0;
		cmd_write = 1'b0;
		avl_address = '0;
		avl_writedata = '0;
		afi_rdata = '0;
		afi_rdata_valid = 1'b0;
		run_active = 1'b0;
		cs_mask = '0;
		odt0_mask = '0;
		odt1_mask = '0;
		for (int i = 0; i < 4; i++) begin
			mdl_cntr[i] = '0;
			mdl_reload[i] = '0;
			mdl_target[i] = '0;
		end
		repeat (10) @(posedge afi_clk);
		#1;
		afi_reset_n = 1'b1;
		if (cmd_done !== 1'b0) begin
			errors++;
			$display("FAIL %0t: cmd_done is not low after reset", $time);
		end
		host_read(8'h00, rd);
		check_word("error word after reset", rd, '0);
		host_read(8'h01, rd);
		check_pc("pc after reset", pc_t'(rd), '0);

		// with both entry 0 ODT selects the masks are still at their reset value
		for (int k = 0; k < 2; k++) begin
			host_cmd(CMD_WRITE_AC, 8'h00, avl_word_t'({k[0], 1'b0, 8'h5a}));
			check_ac("idle ac after reset", {afi_odt, ac_masked_bus, ac_bus},
				acbeat_t'({{CS_WIDTH{1'b0}}, {CS_WIDTH{1'b0}}, 8'h5a}));
		end
		for (int i = 0; i < 8; i++) begin
			ac_tab[i] = ac_word_t'($urandom);
			host_cmd(CMD_WRITE_AC, 8'(i), avl_word_t'(ac_tab[i]));
		end
		cs_mask = CS_WIDTH'($urandom);
		odt0_mask = CS_WIDTH'($urandom);
		odt1_mask = CS_WIDTH'($urandom);
		mask_word = '0;
		mask_word[CS_WIDTH-1:0] = cs_mask;
		mask_word[8 +: CS_WIDTH] = odt0_mask;
		mask_word[16 +: CS_WIDTH] = odt1_mask;
		host_cmd(CMD_SET_MASK, 8'h00, mask_word);

		// straight program whose last instruction returns
		for (int i = 0; i < 4; i++)
			load_inst(pc_t'(10 + i), make_inst(i == 3, 1'b0, 1'b0, 2'd0,
				AC_ADDR_WIDTH'($urandom_range(7, 0))));
		run_program(8'h00, pc_t'(10), final_pc, beats);
		host_read(8'h01, rd);
		check_pc("pc after straight run", pc_t'(rd), pc_t'(13));

		// loop body at 21..22 runs counter+1 times
		loop_n = $urandom_range(6, 0);
		mdl_cntr[1] = CNTR_WIDTH'(loop_n);
		mdl_reload[1] = CNTR_WIDTH'(loop_n);
		mdl_target[1] = pc_t'(21);
		host_cmd(CMD_LOAD_CNTR, 8'd1, avl_word_t'(loop_n));
		host_cmd(CMD_LOAD_JUMP, 8'd1, avl_word_t'(21));
		load_inst(pc_t'(20), make_inst(1'b0, 1'b0, 1'b0, 2'd0, AC_ADDR_WIDTH'(0)));
		load_inst(pc_t'(21), make_inst(1'b0, 1'b0, 1'b0, 2'd0, AC_ADDR_WIDTH'(1)));
		load_inst(pc_t'(22), make_inst(1'b0, 1'b0, 1'b1, 2'd1, AC_ADDR_WIDTH'(2)));
		load_inst(pc_t'(23), make_inst(1'b1, 1'b0, 1'b0, 2'd0, AC_ADDR_WIDTH'(3)));
		run_program(8'h00, pc_t'(20), final_pc, beats);
		if (beats != 2 * (loop_n + 1) + 2) begin
			errors++;
			$display("FAIL %0t: loop with counter %0d ran %0d beats, expected %0d",
				$time, loop_n, beats, 2 * (loop_n + 1) + 2);
		end
		host_read(8'h01, rd);
		check_pc("pc after loop run", pc_t'(rd), final_pc);

		// loopback checks the generated write data against itself
		for (int i = 0; i < 3; i++)
			load_inst(pc_t'(30 + i), make_inst(i == 2, 1'b1, 1'b0, 2'd0, AC_ADDR_WIDTH'(4 + i)));
		run_program(8'h80, pc_t'(30), final_pc, beats);
		host_read(8'h00, rd);
		check_word("error word after loopback", rd, '0);

		// external read on group 1 with group 0 inverted so a wrong select shows up
		rd_inst = make_inst(1'b1, 1'b1, 1'b0, 2'd0, AC_ADDR_WIDTH'(5));
		load_inst(pc_t'(40), rd_inst);
		run_program(8'h01, pc_t'(40), final_pc, beats);
		flip_w = $urandom_range(NUM_WORDS - 1, 0);
		flip_b = $urandom_range(DQ_PER_DQS - 1, 0);
		beat = pattern_beat(rd_inst.do_code, rd_inst.dm_code);
		@(posedge afi_clk);
		#1;
		afi_rdata = beat[WDATA_W-1:0];
		afi_rdata[DQ_PER_DQS-1:0] = ~afi_rdata[DQ_PER_DQS-1:0];
		afi_rdata[(flip_w*DQS_GROUPS + 1)*DQ_PER_DQS + flip_b] =
			~afi_rdata[(flip_w*DQS_GROUPS + 1)*DQ_PER_DQS + flip_b];
		afi_rdata_valid = 1'b1;
		@(posedge afi_clk);
		#1;
		afi_rdata_valid = 1'b0;
		afi_rdata = '0;
		repeat (3) @(posedge afi_clk);
		host_read(8'h00, rd);
		check_word("error word after corrupted beat", rd, avl_word_t'(1) << flip_b);
		host_cmd(CMD_CLEAR_ERR, 8'h01, '0);
		host_read(8'h00, rd);
		check_word("error word after clear", rd, '0);
		host_read(8'h01, rd);
		check_pc("pc after external run", pc_t'(rd), final_pc);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

//--- src.f
src/rw_mgr_cfg_pkg.sv
src/rw_mgr_isa_pkg.sv
src/rw_mgr_cmd_decoder.sv
src/rw_mgr_sequencer.sv
src/rw_mgr_jump_logic.sv
src/rw_mgr_ac_table.sv
src/rw_mgr_write_path.sv
src/rw_mgr_read_checker.sv
src/rw_mgr_core.sv
tests/tb_rw_mgr_core.sv

//--- Bender.yml
package:
  name: rw_mgr_core

sources:
  - src/rw_mgr_cfg_pkg.sv
  - src/rw_mgr_isa_pkg.sv
  - src/rw_mgr_cmd_decoder.sv
  - src/rw_mgr_sequencer.sv
  - src/rw_mgr_jump_logic.sv
  - src/rw_mgr_ac_table.sv
  - src/rw_mgr_write_path.sv
  - src/rw_mgr_read_checker.sv
  - src/rw_mgr_core.sv
  - target: test
    files:
      - tests/tb_rw_mgr_core.sv
